// ==== axi_core_bridge.f ====
+incdir+hdl
hdl/axi_pkg.sv
hdl/core_pkg.sv
hdl/lane_align.sv
hdl/bus_sequencer.sv
hdl/axi_core_bridge.sv
testbench/axi_core_bridge_assertions.sv
testbench/axi_core_bridge_tb.sv

// ==== hdl/axi_core_bridge.sv ====
`timescale 1ns/100ps

module axi_core_bridge
    import core_pkg::*, axi_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  addr_t    fetch_pc,
    input  mem_req_t mem_req,
    output word_t    instr,
    output logic     instr_valid,
    output word_t    load_data,
    output logic     mem_done,
    output axi_ax_t  ar,
    output logic     ar_valid,
    input  logic     ar_ready,
    output axi_ax_t  aw,
    output logic     aw_valid,
    input  logic     aw_ready,
    output axi_w_t   w,
    output logic     w_valid,
    input  logic     w_ready,
    input  axi_b_t   b,
    input  logic     b_valid,
    output logic     b_ready,
    input  axi_r_t   r,
    input  logic     r_valid,
    output logic     r_ready
);

    logic     fetch;
    mem_req_t req_q;

    bus_sequencer u_seq (
        .clock       (clock),
        .reset       (reset),
        .fetch_pc    (fetch_pc),
        .mem_req     (mem_req),
        .ar_ready    (ar_ready),
        .aw_ready    (aw_ready),
        .w_ready     (w_ready),
        .b_valid     (b_valid),
        .r_valid     (r_valid),
        .r           (r),
        .ar_valid    (ar_valid),
        .aw_valid    (aw_valid),
        .w_valid     (w_valid),
        .b_ready     (b_ready),
        .r_ready     (r_ready),
        .fetch       (fetch),
        .req_q       (req_q),
        .instr       (instr),
        .instr_valid (instr_valid),
        .mem_done    (mem_done)
    );

    lane_align u_align (
        .fetch     (fetch),
        .fetch_pc  (fetch_pc),
        .req       (req_q),
        .rdata     (r.data),
        .ar_pay    (ar),
        .aw_pay    (aw),
        .w_pay     (w),
        .load_word (load_data)
    );

endmodule

// ==== hdl/axi_pkg.sv ====
`include "bus_defines.svh"

package axi_pkg;

    typedef logic [`XLEN-1:0]   axi_addr_t;
    typedef logic [`XLEN-1:0]   axi_data_t;
    typedef logic [`XLEN/8-1:0] axi_strb_t;
    typedef logic [2:0]         axi_size_t;  // log2 of bytes per beat
    typedef logic [7:0]         axi_len_t;   // Beats minus one
    typedef logic [1:0]         axi_burst_t;
    typedef logic [3:0]         axi_id_t;
    typedef logic [1:0]         axi_resp_t;

    localparam axi_burst_t BURST_INCR = 2'b01;

    // Shared by AW and AR
    typedef struct packed {
        axi_addr_t  addr;
        axi_size_t  size;
        axi_len_t   len;
        axi_burst_t burst;
        axi_id_t    id;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_resp_t resp;
        axi_id_t   id;
    } axi_b_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
        axi_id_t   id;
    } axi_r_t;

endpackage

// ==== hdl/bus_defines.svh ====
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// Data and address width of the core and the AXI port
`define XLEN 32

// Main memory, aligned for reads and writes
`define MEM_LO 32'h0F00_0000
`define MEM_HI 32'h0FFF_FFFF

// Device registers, aligned for reads and writes
`define DEV_LO 32'h1000_0000
`define DEV_HI 32'h1000_0FFF

// Boot ROM, aligned for reads only
`define ROM_LO 32'h2000_0000
`define ROM_HI 32'h2000_0FFF

`endif

// ==== hdl/bus_sequencer.sv ====
`timescale 1ns/100ps

module bus_sequencer
    import core_pkg::*, axi_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  addr_t    fetch_pc,
    input  mem_req_t mem_req,
    input  logic     ar_ready,
    input  logic     aw_ready,
    input  logic     w_ready,
    input  logic     b_valid,
    input  logic     r_valid,
    input  axi_r_t   r,
    output logic     ar_valid,
    output logic     aw_valid,
    output logic     w_valid,
    output logic     b_ready,
    output logic     r_ready,
    output logic     fetch,
    output mem_req_t req_q,
    output word_t    instr,
    output logic     instr_valid,
    output logic     mem_done
);

    bus_state_e state;
    bus_state_e next_state;
    logic       ar_done;
    logic       r_done;

    assign ar_done = ar_valid && ar_ready;
    assign r_done  = r_valid && r_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                next_state = FETCH_AR;
            end
            FETCH_AR: begin
                if (ar_done) begin
                    next_state = FETCH_R;
                end
            end
            FETCH_R: begin
                if (r_done) begin
                    next_state = EXEC;
                end
            end
            EXEC: begin
                case (mem_req.op)
                    MEM_STORE: next_state = STORE_AW;
                    MEM_LOAD:  next_state = LOAD_AR;
                    default:   next_state = FETCH_AR;
                endcase
            end
            STORE_AW: begin
                if (aw_valid && aw_ready) begin
                    next_state = STORE_W;
                end
            end
            STORE_W: begin
                if (w_valid && w_ready) begin
                    next_state = STORE_B;
                end
            end
            STORE_B: begin
                if (b_valid && b_ready) begin
                    next_state = FETCH_AR;
                end
            end
            LOAD_AR: begin
                if (ar_done) begin
                    next_state = LOAD_R;
                end
            end
            LOAD_R: begin
                if (r_done) begin
                    next_state = FETCH_AR;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            instr <= '0;
        end else if (state == FETCH_R && r_done) begin
            instr <= r.data;
        end
    end

    // Held through the store or load phases
    always_ff @(posedge clock) begin
        if (state == EXEC) begin
            req_q <= mem_req;
        end
    end

    assign fetch = (state == FETCH_AR) || (state == FETCH_R);

    assign ar_valid = (state == FETCH_AR) || (state == LOAD_AR);
    assign aw_valid = (state == STORE_AW);
    assign w_valid  = (state == STORE_W);
    assign b_ready  = (state == STORE_B);
    assign r_ready  = (state == FETCH_R) || (state == LOAD_R);

    assign instr_valid = (state == EXEC);

    // No memory access completes in EXEC itself
    assign mem_done = ((state == EXEC) && (mem_req.op == MEM_NONE)) ||
                      ((state == STORE_B) && b_valid) ||
                      ((state == LOAD_R) && r_valid);

endmodule

// ==== hdl/core_pkg.sv ====
`include "bus_defines.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`XLEN-1:0]   addr_t;
    typedef logic [`XLEN/8-1:0] byte_mask_t;  // 0001, 0011 or 1111

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef struct packed {
        mem_op_e    op;
        addr_t      addr;
        word_t      wdata;
        byte_mask_t mask;
    } mem_req_t;

    typedef enum logic [3:0] {
        IDLE,
        FETCH_AR,
        FETCH_R,
        EXEC,
        STORE_AW,
        STORE_W,
        STORE_B,
        LOAD_AR,
        LOAD_R
    } bus_state_e;

endpackage

// ==== hdl/lane_align.sv ====
`timescale 1ns/100ps
`include "bus_defines.svh"

module lane_align
    import core_pkg::*, axi_pkg::*;
(
    input  logic     fetch,
    input  addr_t    fetch_pc,
    input  mem_req_t req,
    input  word_t    rdata,
    output axi_ax_t  ar_pay,
    output axi_ax_t  aw_pay,
    output axi_w_t   w_pay,
    output word_t    load_word
);

    logic       in_mem;
    logic       in_dev;
    logic       in_rom;
    logic       wr_align;
    logic       rd_align;
    logic [1:0] offset;
    addr_t      word_addr;
    axi_size_t  req_size;

    function automatic axi_size_t mask_size(input byte_mask_t mask);
        axi_size_t size;
        case (mask)
            4'b0001: size = 3'd0;
            4'b0011: size = 3'd1;
            default: size = 3'd2;
        endcase
        return size;
    endfunction

    assign in_mem = (req.addr >= `MEM_LO) && (req.addr <= `MEM_HI);
    assign in_dev = (req.addr >= `DEV_LO) && (req.addr <= `DEV_HI);
    assign in_rom = (req.addr >= `ROM_LO) && (req.addr <= `ROM_HI);

    assign wr_align = in_mem || in_dev;
    assign rd_align = in_mem || in_dev || in_rom;  // ROM is read-only

    assign offset    = req.addr[1:0];
    assign word_addr = {req.addr[`XLEN-1:2], 2'b00};
    assign req_size  = mask_size(req.mask);

    always_comb begin
        aw_pay.addr  = wr_align ? word_addr : req.addr;
        aw_pay.size  = req_size;
        aw_pay.len   = '0;
        aw_pay.burst = BURST_INCR;
        aw_pay.id    = '0;
    end

    always_comb begin
        w_pay.data = wr_align ? req.wdata << {offset, 3'b000} : req.wdata;
        w_pay.strb = wr_align ? req.mask << offset : req.mask;
        w_pay.last = 1'b1;  // Single beat
    end

    always_comb begin
        if (fetch) begin
            ar_pay.addr = fetch_pc;
            ar_pay.size = 3'd2;
        end else begin
            ar_pay.addr = rd_align ? word_addr : req.addr;
            ar_pay.size = req_size;
        end
        ar_pay.len   = '0;
        ar_pay.burst = BURST_INCR;
        ar_pay.id    = '0;
    end

    // Byte lanes back down to bit 0, zero filled
    assign load_word = (!fetch && rd_align) ? rdata >> {offset, 3'b000} : rdata;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --assert --top-module axi_core_bridge_tb \
    -f axi_core_bridge.f -o axi_core_bridge_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/axi_core_bridge_sim > sim.log 2>&1
cat sim.log

grep -qx "Test passed" sim.log && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }

// ==== testbench/axi_core_bridge_assertions.sv ====
`timescale 1ns/100ps

module axi_core_bridge_assertions
    import core_pkg::*;
(
    input logic       clock,
    input logic       reset,
    input addr_t      fetch_pc,
    input logic       ar_valid,
    input logic       ar_ready,
    input logic       aw_valid,
    input logic       aw_ready,
    input logic       w_valid,
    input logic       w_ready,
    input logic       fetch,
    input mem_req_t   req_q,
    input bus_state_e state
);

    // Read payload comes from fetch_pc on a fetch, else from req_q
    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(fetch) && $stable(req_q) &&
                                  (!fetch || $stable(fetch_pc)))
        else $error("ar_valid or its payload changed before ar_ready");

    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(req_q))
        else $error("aw_valid or its payload changed before aw_ready");

    a_w_hold: assert property (@(posedge clock) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(req_q))
        else $error("w_valid or its payload changed before w_ready");

    a_one_valid: assert property (@(posedge clock) disable iff (reset)
        $onehot0({ar_valid, aw_valid, w_valid}))
        else $error("more than one request valid at once");

    a_reset: assert property (@(posedge clock)
        reset |=> !ar_valid && !aw_valid && !w_valid && state == IDLE)
        else $error("valids not low after reset");

endmodule

bind bus_sequencer axi_core_bridge_assertions u_assert (
    .clock    (clock),
    .reset    (reset),
    .fetch_pc (fetch_pc),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .fetch    (fetch),
    .req_q    (req_q),
    .state    (state)
);

// ==== testbench/axi_core_bridge_tb.sv ====
`timescale 1ns/100ps

module axi_core_bridge_tb
    import core_pkg::*, axi_pkg::*;
();

    localparam int NUM_INSTR   = 40;
    localparam int CYCLE_LIMIT = NUM_INSTR * 40 + 100;  // Worst fetch plus store is under 30

    typedef struct packed {
        addr_t      addr;
        axi_size_t  size;
        word_t      wdata;
        byte_mask_t strb;
        word_t      load_data;
    } beat_t;

    logic     clock;
    logic     reset;
    addr_t    fetch_pc;
    mem_req_t mem_req;
    word_t    instr;
    logic     instr_valid;
    word_t    load_data;
    logic     mem_done;
    axi_ax_t  ar;
    logic     ar_valid;
    logic     ar_ready;
    axi_ax_t  aw;
    logic     aw_valid;
    logic     aw_ready;
    axi_w_t   w;
    logic     w_valid;
    logic     w_ready;
    axi_b_t   b;
    logic     b_valid;
    logic     b_ready;
    axi_r_t   r;
    logic     r_valid;
    logic     r_ready;

    integer   seed;
    word_t    mem [addr_t];  // Sparse slave memory
    mem_req_t reqs [NUM_INSTR];
    addr_t    pcs [NUM_INSTR];
    int       cur;
    int       errors;
    int       inst_errs;
    int       done_count;
    int       cycles;
    int       n_ar;
    int       n_aw;
    int       n_w;
    int       n_b;
    int       n_r;
    logic     fetched;  // Instruction of cur already executed
    logic     exec_due;  // Fetch data arrived, EXEC next

    axi_core_bridge UUT (
        .clock       (clock),
        .reset       (reset),
        .fetch_pc    (fetch_pc),
        .mem_req     (mem_req),
        .instr       (instr),
        .instr_valid (instr_valid),
        .load_data   (load_data),
        .mem_done    (mem_done),
        .ar          (ar),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b           (b),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .r           (r),
        .r_valid     (r_valid),
        .r_ready     (r_ready)
    );

    always #50 clock = ~clock;

    function automatic addr_t word_key(input addr_t a);
        return {a[31:2], 2'b00};
    endfunction

    function automatic word_t mem_read(input addr_t a);
        addr_t k;
        k = word_key(a);
        if (mem.exists(k)) begin
            return mem[k];
        end
        return k ^ {k[15:0], k[31:16]} ^ 32'h3c5a_96e1;  // Fill from the full address
    endfunction

    // 0 outside, 1 memory, 2 device, 3 boot ROM
    function automatic int region_of(input addr_t a);
        if (a >= 32'h0F00_0000 && a <= 32'h0FFF_FFFF) return 1;
        if (a >= 32'h1000_0000 && a <= 32'h1000_0FFF) return 2;
        if (a >= 32'h2000_0000 && a <= 32'h2000_0FFF) return 3;
        return 0;
    endfunction

    function automatic beat_t expected_beat(input mem_req_t req, input word_t mem_word);
        beat_t e;
        int    reg_id;
        logic  wr_al;
        logic  rd_al;
        int    sh;
        reg_id = region_of(req.addr);
        wr_al = (reg_id == 1) || (reg_id == 2);
        rd_al = (reg_id != 0);
        sh = 8 * int'(req.addr[1:0]);
        if (req.mask == 4'b0001) e.size = 3'd0;
        else if (req.mask == 4'b0011) e.size = 3'd1;
        else e.size = 3'd2;
        if (req.op == MEM_STORE) begin
            e.addr = wr_al ? word_key(req.addr) : req.addr;
        end else begin
            e.addr = rd_al ? word_key(req.addr) : req.addr;
        end
        e.wdata = wr_al ? (req.wdata << sh) : req.wdata;
        e.strb = wr_al ? (req.mask << req.addr[1:0]) : req.mask;
        e.load_data = rd_al ? (mem_word >> sh) : mem_word;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            inst_errs++;
        end
    endtask

    task automatic make_request(output addr_t pc, output mem_req_t req);
        logic [31:0] rnd;
        int          kind;
        byte_mask_t  mask;
        logic [1:0]  off;
        addr_t       base;
        rnd = $random(seed);
        pc = 32'h0F00_0000 | (rnd & 32'h00FF_FFFC);
        kind = int'(rnd[31:16] % 16'd5);
        rnd = $random(seed);
        if (rnd[3:2] == 2'd1) begin
            mask = 4'b0011;
            off = {rnd[0], 1'b0};
        end else if (rnd[3:2] == 2'd2) begin
            mask = 4'b0001;
            off = rnd[1:0];
        end else begin
            mask = 4'b1111;
            off = 2'd0;
        end
        rnd = $random(seed);
        if (kind == 1) begin
            base = rnd[31] ? (32'h1000_0000 | (rnd & 32'h0000_0FFC))
                           : (32'h0F00_0000 | (rnd & 32'h00FF_FFFC));
        end else if (kind == 3) begin
            if (rnd[31:30] == 2'd0) base = 32'h0F00_0000 | (rnd & 32'h00FF_FFFC);
            else if (rnd[31:30] == 2'd1) base = 32'h1000_0000 | (rnd & 32'h0000_0FFC);
            else base = 32'h2000_0000 | (rnd & 32'h0000_0FFC);
        end else begin
            base = 32'h3000_0000 | (rnd & 32'h0000_FFFC);  // No region here
        end
        req.op = (kind == 0) ? MEM_NONE : (kind <= 2) ? MEM_STORE : MEM_LOAD;
        req.addr = base | {30'd0, off};
        req.wdata = $random(seed);
        req.mask = mask;
    endtask

    task automatic ready_delay();
        logic [31:0] rnd;
        rnd = $random(seed);
        repeat (rnd[1:0]) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic serve_read();
        addr_t a;
        a = ar.addr;
        @(posedge clock);
        #1;
        ready_delay();
        ar_ready = 1'b1;
        @(posedge clock);
        #1;
        ar_ready = 1'b0;
        ready_delay();
        r.data = mem_read(a);
        r_valid = 1'b1;
        @(posedge clock);
        #1;
        r_valid = 1'b0;
    endtask

    task automatic serve_write();
        addr_t  a;
        axi_w_t wd;
        word_t  word;
        a = aw.addr;
        @(posedge clock);
        #1;
        ready_delay();
        aw_ready = 1'b1;
        @(posedge clock);
        #1;
        aw_ready = 1'b0;
        ready_delay();
        w_ready = 1'b1;
        wd = w;
        @(posedge clock);
        #1;
        w_ready = 1'b0;
        word = mem_read(a);
        for (int k = 0; k < 4; k++) begin
            if (wd.strb[k]) word[8*k +: 8] = wd.data[8*k +: 8];
        end
        mem[word_key(a)] = word;
        ready_delay();
        b_valid = 1'b1;
        @(posedge clock);
        #1;
        b_valid = 1'b0;
    endtask

    // Slave side, one transaction at a time
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && ar_valid) serve_read();
            else if (!reset && aw_valid) serve_write();
        end
    end

    task automatic compare_cycle();
        mem_req_t req;
        beat_t    e;
        logic     exp_done;
        req = reqs[cur];
        e = expected_beat(req, mem_read(req.addr));
        if (ar_valid && ar_ready) begin
            n_ar++;
            check_value("ar.addr", ar.addr, fetched ? e.addr : pcs[cur]);
            check_value("ar.size", 32'(ar.size), fetched ? 32'(e.size) : 32'd2);
            check_value("ar.len", 32'(ar.len), 32'd0);
            check_value("ar.burst", 32'(ar.burst), 32'd1);  // INCR
            check_value("ar.id", 32'(ar.id), 32'd0);
        end
        if (aw_valid && aw_ready) begin
            n_aw++;
            check_value("aw.addr", aw.addr, e.addr);
            check_value("aw.size", 32'(aw.size), 32'(e.size));
            check_value("aw.len", 32'(aw.len), 32'd0);
            check_value("aw.burst", 32'(aw.burst), 32'd1);
            check_value("aw.id", 32'(aw.id), 32'd0);
        end
        if (w_valid && w_ready) begin
            n_w++;
            check_value("w.data", w.data, e.wdata);
            check_value("w.strb", 32'(w.strb), 32'(e.strb));
            check_value("w.last", 32'(w.last), 32'd1);
        end
        if (b_valid && b_ready) n_b++;
        if (r_valid && r_ready) n_r++;
        exp_done = (instr_valid && req.op == MEM_NONE) || (b_valid && b_ready) ||
                   (r_valid && r_ready && fetched);
        check_value("instr_valid", 32'(instr_valid), 32'(exec_due));
        exec_due = r_valid && r_ready && !fetched;
        if (instr_valid) begin
            check_value("instr", instr, mem_read(pcs[cur]));
            fetched = 1'b1;
        end
        check_value("mem_done", 32'(mem_done), 32'(exp_done));
        if (mem_done || exp_done) begin
            if (req.op == MEM_LOAD) check_value("load_data", load_data, e.load_data);
            check_value("ar transfers", 32'(n_ar), (req.op == MEM_LOAD) ? 32'd2 : 32'd1);
            check_value("r transfers", 32'(n_r), (req.op == MEM_LOAD) ? 32'd2 : 32'd1);
            check_value("aw transfers", 32'(n_aw), (req.op == MEM_STORE) ? 32'd1 : 32'd0);
            check_value("w transfers", 32'(n_w), (req.op == MEM_STORE) ? 32'd1 : 32'd0);
            check_value("b transfers", 32'(n_b), (req.op == MEM_STORE) ? 32'd1 : 32'd0);
            $display("instr %0d %s at %h: %0d mismatches", cur, req.op.name(), req.addr,
                     inst_errs);
            done_count++;
            inst_errs = 0;
            fetched = 1'b0;
            n_ar = 0;
            n_aw = 0;
            n_w = 0;
            n_b = 0;
            n_r = 0;
        end
    endtask

    always @(negedge clock) begin
        if (!reset) compare_cycle();
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions done",
                     cycles, done_count, NUM_INSTR);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        seed = 32'habd496c4;
        clock = 1'b0;
        reset = 1'b1;
        fetch_pc = '0;
        mem_req = '0;
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b = '0;  // OKAY, id 0
        b_valid = 1'b0;
        r = '0;
        r.last = 1'b1;
        r_valid = 1'b0;
        errors = 0;
        inst_errs = 0;
        done_count = 0;
        cycles = 0;
        n_ar = 0;
        n_aw = 0;
        n_w = 0;
        n_b = 0;
        n_r = 0;
        fetched = 1'b0;
        exec_due = 1'b0;
        cur = 0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            make_request(pcs[i], reqs[i]);
        end
        fetch_pc = pcs[0];
        mem_req = reqs[0];
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_value("reset valids", 32'({ar_valid, aw_valid, w_valid}), 32'd0);
        check_value("reset readies", 32'({b_ready, r_ready}), 32'd0);
        check_value("reset instr_valid", 32'(instr_valid), 32'd0);
        check_value("reset mem_done", 32'(mem_done), 32'd0);
        check_value("reset instr", instr, 32'd0);
        for (int i = 0; i < NUM_INSTR; i++) begin
            cur = i;
            fetch_pc = pcs[i];
            mem_req = reqs[i];  // Held until this instruction's mem_done
            do @(negedge clock); while (!mem_done);
            @(posedge clock);
            #1;
        end
        $display("Done: %0d of %0d instructions, %0d errors", done_count, NUM_INSTR, errors);
        if (errors == 0 && done_count == NUM_INSTR) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
